// File: Makefile
VERILATOR ?= verilator
TOP       ?= fp_mul_tb
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary -j 0 -Wno-fatal
FAIL_MSG  ?= TB FAILED

SIM_BIN := $(BUILD_DIR)/V$(TOP)
SOURCES := $(shell cat $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# the log decides the result; a crash of the binary also counts as failure
run: compile
	@./$(SIM_BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
	    echo "simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: hdl/fp_mul_booth.sv
module fp_mul_booth (
    input  logic                                     clk,
    input  logic                                     rst_n,
    input  logic                                     u_valid,
    input  logic                                     u_sign,
    input  logic signed [fp_mul_pkg::exp_ext_w-1:0]  u_exp,
    input  logic [1:0]                               u_kind,
    input  fp_mul_pkg::rmode_t                       u_mode,
    input  logic [fp_mul_pkg::sig_w-1:0]             sig_x,
    input  logic [fp_mul_pkg::sig_w-1:0]             sig_y,
    output logic                                     b_valid,
    output logic                                     b_sign,
    output logic signed [fp_mul_pkg::exp_ext_w-1:0]  b_exp,
    output logic [1:0]                               b_kind,
    output fp_mul_pkg::rmode_t                       b_mode,
    output logic [fp_mul_pkg::prod_w-1:0]            prod
);

    import fp_mul_pkg::*;

    // multiplier with an implicit zero below bit 0 and zero padding on top
    logic [2*booth_n:0] y_ext;
    logic [prod_w-1:0]  x_ext;
    logic [prod_w-1:0]  x_dbl;
    logic [prod_w-1:0]  pp;
    logic [prod_w-1:0]  acc;
    logic [2:0]         grp;

    assign y_ext = {{(2*booth_n-sig_w){1'b0}}, sig_y, 1'b0};
    assign x_ext = {{(prod_w-sig_w){1'b0}}, sig_x};
    assign x_dbl = x_ext << 1;

    // sum of the recoded partial products, modulo 2^48
    // negative digits wrap around and cancel out in the final sum
    always_comb begin
        acc = '0;
        grp = '0;
        pp  = '0;
        for (int i = 0; i < booth_n; i++) begin
            grp = y_ext[2*i +: 3];
            case (grp)
                3'b001, 3'b010: begin
                    pp = x_ext;
                end
                3'b011: begin
                    pp = x_dbl;
                end
                3'b100: begin
                    pp = ~x_dbl + 1'b1;
                end
                3'b101, 3'b110: begin
                    pp = ~x_ext + 1'b1;
                end
                default: begin
                    // digit 0
                    pp = '0;
                end
            endcase
            acc = acc + (pp << (2 * i));
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            b_valid <= 1'b0;
        end else begin
            b_valid <= u_valid;
        end
    end

    always_ff @(posedge clk) begin
        b_sign <= u_sign;
        b_exp  <= u_exp;
        b_kind <= u_kind;
        b_mode <= u_mode;
        // specials carry no significand
        if (u_kind == kind_fin) begin
            prod <= acc;
        end else begin
            prod <= '0;
        end
    end

endmodule

// File: hdl/fp_mul_norm.sv
module fp_mul_norm (
    input  logic                                     clk,
    input  logic                                     rst_n,
    input  logic                                     b_valid,
    input  logic                                     b_sign,
    input  logic signed [fp_mul_pkg::exp_ext_w-1:0]  b_exp,
    input  logic [1:0]                               b_kind,
    input  fp_mul_pkg::rmode_t                       b_mode,
    input  logic [fp_mul_pkg::prod_w-1:0]            prod,
    output logic                                     n_valid,
    output logic                                     n_sign,
    output logic signed [fp_mul_pkg::exp_ext_w-1:0]  n_exp,
    output logic [1:0]                               n_kind,
    output fp_mul_pkg::rmode_t                       n_mode,
    output logic [fp_mul_pkg::norm_w-1:0]            frac_n
);

    import fp_mul_pkg::*;

    logic                        msb;
    logic [norm_w-1:0]           frac_c;
    logic signed [exp_ext_w-1:0] exp_c;

    // product of two 1.x values is in [1,4), so at most one shift
    assign msb = prod[prod_w-1];

    always_comb begin
        if (msb) begin
            frac_c = {prod[prod_w-2 -: norm_w-1], |prod[prod_w-norm_w-1:0]};
            exp_c  = b_exp + exp_ext_w'(1);
        end else begin
            frac_c = {prod[prod_w-3 -: norm_w-1], |prod[prod_w-norm_w-2:0]};
            exp_c  = b_exp;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            n_valid <= 1'b0;
        end else begin
            n_valid <= b_valid;
        end
    end

    always_ff @(posedge clk) begin
        n_sign <= b_sign;
        n_exp  <= exp_c;
        n_kind <= b_kind;
        n_mode <= b_mode;
        frac_n <= frac_c;
    end

endmodule

// File: hdl/fp_mul_pkg.sv
package fp_mul_pkg;

    // ieee-754 single precision field widths
    localparam int exp_w  = 8;
    localparam int frac_w = 23;
    localparam int bias   = 127;

    // internal exponent carries sign and headroom for the product sum
    localparam int exp_ext_w = 10;

    // largest biased exponent of a normal number
    localparam int exp_max = 254;

    // significand with hidden bit, and the full product
    localparam int sig_w  = frac_w + 1;
    localparam int prod_w = 2 * sig_w;

    // normalized fraction plus guard, round and sticky
    localparam int norm_w = frac_w + 3;

    // radix-4 digits needed for an unsigned significand
    localparam int booth_n = sig_w / 2 + 1;

    // special constants
    localparam logic [31:0]      qnan_word      = 32'h7FC0_0000;
    localparam logic [exp_w-1:0] inf_exp        = 8'hFF;
    localparam logic [31:0]      max_finite_mag = 32'h7F7F_FFFF;

    // kind of value carried down the pipeline
    localparam logic [1:0] kind_fin  = 2'd0;
    localparam logic [1:0] kind_zero = 2'd1;
    localparam logic [1:0] kind_inf  = 2'd2;
    localparam logic [1:0] kind_nan  = 2'd3;

    // codes 5 to 7 fall back to nearest-even
    typedef enum logic [2:0] {
        rne = 3'd0,
        rtz = 3'd1,
        rdn = 3'd2,
        rup = 3'd3,
        rmm = 3'd4
    } rmode_t;

    typedef struct packed {
        logic              sign;
        logic [exp_w-1:0]  exp;
        logic [frac_w-1:0] frac;
    } fp_fields_t;

    typedef union packed {
        logic [31:0] raw;
        fp_fields_t  f;
    } fp_word_t;

endpackage

// File: hdl/fp_mul_round.sv
module fp_mul_round (
    input  logic                                     clk,
    input  logic                                     rst_n,
    input  logic                                     n_valid,
    input  logic                                     n_sign,
    input  logic signed [fp_mul_pkg::exp_ext_w-1:0]  n_exp,
    input  logic [1:0]                               n_kind,
    input  fp_mul_pkg::rmode_t                       n_mode,
    input  logic [fp_mul_pkg::norm_w-1:0]            frac_n,
    output logic                                     out_valid,
    output fp_mul_pkg::fp_word_t                     fp_z,
    output logic                                     ovrf,
    output logic                                     udrf
);

    import fp_mul_pkg::*;

    logic [frac_w-1:0]           frac;
    logic                        guard;
    logic                        rnd_bit;
    logic                        sticky;
    logic                        inexact;
    logic                        inc;
    logic [frac_w:0]             frac_r;
    logic signed [exp_ext_w-1:0] exp_r;
    logic                        ovf_c;
    logic                        udf_c;
    logic                        to_inf;
    fp_word_t                    z_next;

    assign frac    = frac_n[norm_w-1:3];
    assign guard   = frac_n[2];
    assign rnd_bit = frac_n[1];
    assign sticky  = frac_n[0];
    assign inexact = guard | rnd_bit | sticky;

    // increment decision per mode
    always_comb begin
        case (n_mode)
            rtz:     inc = 1'b0;
            rdn:     inc = n_sign & inexact;
            rup:     inc = ~n_sign & inexact;
            rmm:     inc = guard;
            default: inc = guard & (rnd_bit | sticky | frac[0]);
        endcase
    end

    // carry out leaves the low fraction bits at zero already
    assign frac_r = {1'b0, frac} + (frac_w+1)'(inc);
    assign exp_r  = n_exp + exp_ext_w'(frac_r[frac_w]);

    assign ovf_c = (n_kind == kind_fin) && (exp_r > exp_max);
    assign udf_c = (n_kind == kind_fin) && (exp_r < exp_ext_w'(1));

    // overflow goes to infinity unless the mode rounds toward zero
    always_comb begin
        case (n_mode)
            rtz:     to_inf = 1'b0;
            rdn:     to_inf = n_sign;
            rup:     to_inf = ~n_sign;
            default: to_inf = 1'b1;
        endcase
    end

    always_comb begin
        z_next.f.sign = n_sign;
        z_next.f.exp  = exp_r[exp_w-1:0];
        z_next.f.frac = frac_r[frac_w-1:0];
        case (n_kind)
            kind_nan: begin
                z_next.raw = qnan_word;
            end
            kind_inf: begin
                z_next.f.exp  = inf_exp;
                z_next.f.frac = '0;
            end
            kind_zero: begin
                z_next.f.exp  = '0;
                z_next.f.frac = '0;
            end
            default: begin
                if (ovf_c && to_inf) begin
                    z_next.f.exp  = inf_exp;
                    z_next.f.frac = '0;
                end else if (ovf_c) begin
                    z_next.raw = {n_sign, max_finite_mag[30:0]};
                end else if (udf_c) begin
                    // flush, no gradual underflow
                    z_next.f.exp  = '0;
                    z_next.f.frac = '0;
                end
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
            ovrf      <= 1'b0;
            udrf      <= 1'b0;
        end else begin
            out_valid <= n_valid;
            ovrf      <= n_valid & ovf_c;
            udrf      <= n_valid & udf_c;
        end
    end

    always_ff @(posedge clk) begin
        fp_z.raw <= z_next.raw;
    end

endmodule

// File: hdl/fp_mul_top.sv
module fp_mul_top (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 in_valid,
    input  fp_mul_pkg::fp_word_t fp_x,
    input  fp_mul_pkg::fp_word_t fp_y,
    input  fp_mul_pkg::rmode_t   r_mode,
    output logic                 out_valid,
    output fp_mul_pkg::fp_word_t fp_z,
    output logic                 ovrf,
    output logic                 udrf
);

    import fp_mul_pkg::*;

    // stage 1 to stage 2
    logic                        u_valid;
    logic                        u_sign;
    logic signed [exp_ext_w-1:0] u_exp;
    logic [1:0]                  u_kind;
    rmode_t                      u_mode;
    logic [sig_w-1:0]            sig_x;
    logic [sig_w-1:0]            sig_y;

    // stage 2 to stage 3
    logic                        b_valid;
    logic                        b_sign;
    logic signed [exp_ext_w-1:0] b_exp;
    logic [1:0]                  b_kind;
    rmode_t                      b_mode;
    logic [prod_w-1:0]           prod;

    // stage 3 to stage 4
    logic                        n_valid;
    logic                        n_sign;
    logic signed [exp_ext_w-1:0] n_exp;
    logic [1:0]                  n_kind;
    rmode_t                      n_mode;
    logic [norm_w-1:0]           frac_n;

    fp_mul_unpack unpack_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .in_valid (in_valid),
        .fp_x     (fp_x),
        .fp_y     (fp_y),
        .r_mode   (r_mode),
        .u_valid  (u_valid),
        .u_sign   (u_sign),
        .u_exp    (u_exp),
        .u_kind   (u_kind),
        .u_mode   (u_mode),
        .sig_x    (sig_x),
        .sig_y    (sig_y)
    );

    fp_mul_booth booth_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .u_valid (u_valid),
        .u_sign  (u_sign),
        .u_exp   (u_exp),
        .u_kind  (u_kind),
        .u_mode  (u_mode),
        .sig_x   (sig_x),
        .sig_y   (sig_y),
        .b_valid (b_valid),
        .b_sign  (b_sign),
        .b_exp   (b_exp),
        .b_kind  (b_kind),
        .b_mode  (b_mode),
        .prod    (prod)
    );

    fp_mul_norm norm_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .b_valid (b_valid),
        .b_sign  (b_sign),
        .b_exp   (b_exp),
        .b_kind  (b_kind),
        .b_mode  (b_mode),
        .prod    (prod),
        .n_valid (n_valid),
        .n_sign  (n_sign),
        .n_exp   (n_exp),
        .n_kind  (n_kind),
        .n_mode  (n_mode),
        .frac_n  (frac_n)
    );

    fp_mul_round round_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .n_valid   (n_valid),
        .n_sign    (n_sign),
        .n_exp     (n_exp),
        .n_kind    (n_kind),
        .n_mode    (n_mode),
        .frac_n    (frac_n),
        .out_valid (out_valid),
        .fp_z      (fp_z),
        .ovrf      (ovrf),
        .udrf      (udrf)
    );

endmodule

// File: hdl/fp_mul_unpack.sv
module fp_mul_unpack (
    input  logic                                     clk,
    input  logic                                     rst_n,
    input  logic                                     in_valid,
    input  fp_mul_pkg::fp_word_t                     fp_x,
    input  fp_mul_pkg::fp_word_t                     fp_y,
    input  fp_mul_pkg::rmode_t                       r_mode,
    output logic                                     u_valid,
    output logic                                     u_sign,
    output logic signed [fp_mul_pkg::exp_ext_w-1:0]  u_exp,
    output logic [1:0]                               u_kind,
    output fp_mul_pkg::rmode_t                       u_mode,
    output logic [fp_mul_pkg::sig_w-1:0]             sig_x,
    output logic [fp_mul_pkg::sig_w-1:0]             sig_y
);

    import fp_mul_pkg::*;

    logic x_zero;
    logic x_inf;
    logic x_nan;
    logic y_zero;
    logic y_inf;
    logic y_nan;
    logic [1:0] kind_c;
    logic signed [exp_ext_w-1:0] exp_sum;

    // subnormals have a zero exponent and are flushed to zero here
    assign x_zero = (fp_x.f.exp == '0);
    assign y_zero = (fp_y.f.exp == '0);
    assign x_inf  = (fp_x.f.exp == inf_exp) && (fp_x.f.frac == '0);
    assign y_inf  = (fp_y.f.exp == inf_exp) && (fp_y.f.frac == '0);
    assign x_nan  = (fp_x.f.exp == inf_exp) && (fp_x.f.frac != '0);
    assign y_nan  = (fp_y.f.exp == inf_exp) && (fp_y.f.frac != '0);

    always_comb begin
        if (x_nan || y_nan || (x_zero && y_inf) || (y_zero && x_inf)) begin
            kind_c = kind_nan;
        end else if (x_inf || y_inf) begin
            kind_c = kind_inf;
        end else if (x_zero || y_zero) begin
            kind_c = kind_zero;
        end else begin
            kind_c = kind_fin;
        end
    end

    // biased sum, one bias removed
    assign exp_sum = $signed({2'b00, fp_x.f.exp} + {2'b00, fp_y.f.exp}
                             - exp_ext_w'(bias));

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            u_valid <= 1'b0;
        end else begin
            u_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        u_sign <= fp_x.f.sign ^ fp_y.f.sign;
        u_exp  <= exp_sum;
        u_kind <= kind_c;
        u_mode <= r_mode;
        // hidden bit in front of each fraction
        sig_x  <= {1'b1, fp_x.f.frac};
        sig_y  <= {1'b1, fp_y.f.frac};
    end

endmodule

// File: sim/fp_mul_model.sv
package fp_mul_model;

    import fp_mul_pkg::*;

    localparam logic [31:0] lcg_seed = 32'h3509_fef1;

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    // reference product from the field rules, flush-to-zero on both ends
    function automatic void fp_mul_ref(
        input  logic [31:0] x,
        input  logic [31:0] y,
        input  rmode_t      mode,
        output logic [31:0] z,
        output logic        ovf,
        output logic        udf
    );
        logic        sign;
        logic        x_zero;
        logic        y_zero;
        logic        x_inf;
        logic        y_inf;
        logic        x_nan;
        logic        y_nan;
        logic [47:0] p;
        logic [23:0] m;
        logic [23:0] rem;
        logic [24:0] m_r;
        logic        up;
        int          e;

        sign   = x[31] ^ y[31];
        x_zero = (x[30:23] == 8'h00);
        y_zero = (y[30:23] == 8'h00);
        x_inf  = (x[30:23] == 8'hFF) && (x[22:0] == 23'd0);
        y_inf  = (y[30:23] == 8'hFF) && (y[22:0] == 23'd0);
        x_nan  = (x[30:23] == 8'hFF) && (x[22:0] != 23'd0);
        y_nan  = (y[30:23] == 8'hFF) && (y[22:0] != 23'd0);
        ovf    = 1'b0;
        udf    = 1'b0;
        if (x_nan || y_nan || (x_zero && y_inf) || (x_inf && y_zero)) begin
            z = 32'h7FC0_0000;
        end else if (x_inf || y_inf) begin
            z = {sign, 8'hFF, 23'd0};
        end else if (x_zero || y_zero) begin
            z = {sign, 31'd0};
        end else begin
            p = {24'd0, 1'b1, x[22:0]} * {24'd0, 1'b1, y[22:0]};
            e = int'(x[30:23]) + int'(y[30:23]) - 127;
            if (p[47]) begin
                m   = p[47:24];
                rem = p[23:0];
                e   = e + 1;
            end else begin
                m   = p[46:23];
                rem = {p[22:0], 1'b0};
            end
            // tail scaled so that 24'h800000 is exactly half an ulp
            case (mode)
                rtz:     up = 1'b0;
                rdn:     up = sign && (rem != 24'd0);
                rup:     up = !sign && (rem != 24'd0);
                rmm:     up = (rem >= 24'h80_0000);
                default: up = (rem > 24'h80_0000) || ((rem == 24'h80_0000) && m[0]);
            endcase
            m_r = {1'b0, m} + {24'd0, up};
            if (m_r[24]) begin
                e   = e + 1;
                m_r = m_r >> 1;
            end
            if (e > 254) begin
                ovf = 1'b1;
                if (mode == rtz || (mode == rdn && !sign) || (mode == rup && sign)) begin
                    z = {sign, 31'h7F7F_FFFF};
                end else begin
                    z = {sign, 8'hFF, 23'd0};
                end
            end else if (e < 1) begin
                udf = 1'b1;
                z   = {sign, 31'd0};
            end else begin
                z = {sign, e[7:0], m_r[22:0]};
            end
        end
    endfunction

endpackage

// File: sim/fp_mul_tb.sv
module fp_mul_tb;

    import fp_mul_pkg::*;
    import fp_mul_model::*;

    localparam int wait_limit  = 20;
    localparam int reset_limit = 100;
    localparam int stream_len  = 200;
    localparam int latency     = 4;

    logic        clk;
    logic        rst_n;
    logic        in_valid;
    fp_word_t    fp_x;
    fp_word_t    fp_y;
    rmode_t      r_mode;
    logic        out_valid;
    fp_word_t    fp_z;
    logic        ovrf;
    logic        udrf;
    int          errors;
    int          tests_passed;
    int          tests_failed;
    logic [31:0] lcg_state;

    tb_clock_gen clock_i (
        .clk   (clk),
        .rst_n (rst_n)
    );

    fp_mul_top dut_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .fp_x      (fp_x),
        .fp_y      (fp_y),
        .r_mode    (r_mode),
        .out_valid (out_valid),
        .fp_z      (fp_z),
        .ovrf      (ovrf),
        .udrf      (udrf)
    );

    task automatic check_word(input string name, input fp_word_t expected, input fp_word_t got);
        if (got.raw !== expected.raw) begin
            $display("[FAIL] %s expected %08h got %08h", name, expected.raw, got.raw);
            errors++;
        end
    endtask

    task automatic check_flag(input string name, input logic expected, input logic got);
        if (got !== expected) begin
            $display("[FAIL] %s expected %h got %h", name, expected, got);
            errors++;
        end
    endtask

    task automatic report_test(input string name, input int errors_before);
        if (errors == errors_before) begin
            tests_passed++;
            $display("[PASS] %s", name);
        end else begin
            tests_failed++;
            $display("[ERR ] %s: %0d mismatches", name, errors - errors_before);
        end
    endtask

    function automatic logic [31:0] draw();
        lcg_state = lcg_next(lcg_state);
        return lcg_state;
    endfunction

    // most operands keep a mid-range exponent so products seldom saturate
    function automatic fp_word_t random_operand();
        fp_word_t w;
        w.raw = draw();
        if (w.raw[2:0] != 3'd0) begin
            w.f.exp = 8'h60 + {2'b00, w.raw[28:23]};
        end
        return w;
    endfunction

    task automatic wait_reset();
        int n;
        n = 0;
        while (rst_n !== 1'b1 && n < reset_limit) begin
            @(negedge clk);
            n++;
        end
        if (rst_n !== 1'b1) begin
            $display("reset was never released within %0d cycles", reset_limit);
            errors++;
        end
    endtask

    task automatic wait_output(output logic seen);
        int n;
        seen = 1'b0;
        n    = 0;
        while (!seen && n < wait_limit) begin
            @(negedge clk);
            n++;
            seen = (out_valid === 1'b1);
        end
        if (!seen) begin
            $display("no result strobe within %0d cycles of the operands", wait_limit);
            errors++;
        end
    endtask

    task automatic run_case(input fp_word_t x, input fp_word_t y, input rmode_t mode,
                            input fp_word_t exp_z, input logic exp_ov, input logic exp_ud);
        logic seen;
        @(negedge clk);
        in_valid = 1'b1;
        fp_x     = x;
        fp_y     = y;
        r_mode   = mode;
        @(negedge clk);
        in_valid = 1'b0;
        wait_output(seen);
        if (seen) begin
            check_word("fp_z", exp_z, fp_z);
            check_flag("ovrf", exp_ov, ovrf);
            check_flag("udrf", exp_ud, udrf);
        end
    endtask

    task automatic run_model_case(input fp_word_t x, input fp_word_t y, input rmode_t mode);
        logic [31:0] z;
        logic        ov;
        logic        ud;
        fp_mul_ref(x.raw, y.raw, mode, z, ov, ud);
        run_case(x, y, mode, z, ov, ud);
    endtask

    task automatic test_exact();
        int start;
        start = errors;
        run_case(32'h4040_0000, 32'h4040_0000, rtz, 32'h4110_0000, 1'b0, 1'b0);
        run_case(32'h4000_0000, 32'hBFC0_0000, rne, 32'hC040_0000, 1'b0, 1'b0);
        report_test("exact product", start);
    endtask

    task automatic test_rounding_modes();
        int          start;
        logic [31:0] sgn;
        start = errors;
        for (int m = 0; m < 5; m++) begin
            for (int s = 0; s < 2; s++) begin
                sgn = s[0] ? 32'h8000_0000 : 32'h0;
                // ties on an odd and an even lsb then one product above halfway
                run_model_case(32'h3F80_0001 | sgn, 32'h3FC0_0000, rmode_t'(m));
                run_model_case(32'h3F80_0003 | sgn, 32'h3FC0_0000, rmode_t'(m));
                run_model_case(32'h3F80_0001 | sgn, 32'h3FE0_0000, rmode_t'(m));
            end
        end
        report_test("rounding modes", start);
    endtask

    task automatic test_specials();
        int start;
        start = errors;
        run_case(32'h0000_0000, 32'h3F80_0000, rne, 32'h0000_0000, 1'b0, 1'b0);
        run_case(32'h8000_0000, 32'h3F80_0000, rne, 32'h8000_0000, 1'b0, 1'b0);
        run_case(32'h0000_0001, 32'hC000_0000, rne, 32'h8000_0000, 1'b0, 1'b0);
        run_case(32'h7F80_0000, 32'hC000_0000, rne, 32'hFF80_0000, 1'b0, 1'b0);
        run_case(32'h0000_0000, 32'h7F80_0000, rne, 32'h7FC0_0000, 1'b0, 1'b0);
        run_case(32'h7FC0_0001, 32'h3F80_0000, rne, 32'h7FC0_0000, 1'b0, 1'b0);
        report_test("special values", start);
    endtask

    task automatic test_overflow_underflow();
        int          start;
        logic        to_inf;
        logic [31:0] sgn;
        start = errors;
        for (int m = 0; m < 5; m++) begin
            for (int s = 0; s < 2; s++) begin
                sgn    = s[0] ? 32'h8000_0000 : 32'h0;
                to_inf = (m == 0) || (m == 4) || (m == 2 && s == 1) || (m == 3 && s == 0);
                run_case(32'h7F00_0000 | sgn, 32'h4080_0000, rmode_t'(m),
                         to_inf ? (32'h7F80_0000 | sgn) : (32'h7F7F_FFFF | sgn), 1'b1, 1'b0);
            end
        end
        run_case(32'h0080_0000, 32'h0080_0000, rne, 32'h0000_0000, 1'b0, 1'b1);
        run_case(32'h8080_0000, 32'h0080_0000, rne, 32'h8000_0000, 1'b0, 1'b1);
        report_test("overflow and underflow", start);
    endtask

    // significands multiply to 2^47 - 2^22 so the product sits just below 1.0
    task automatic test_round_carry();
        int start;
        start = errors;
        run_case(32'h3F11_8E00, 32'h3FE1_2000, rup, 32'h3F80_0000, 1'b0, 1'b0);
        run_case(32'h3F11_8E00, 32'h3FE1_2000, rtz, 32'h3F7F_FFFF, 1'b0, 1'b0);
        report_test("rounding carry", start);
    endtask

    task automatic test_stream();
        logic [31:0] word_q[$];
        logic [1:0]  flag_q[$];
        int          issue_q[$];
        int          start;
        int          cycle;
        int          sent;
        int          idle;
        logic [31:0] z;
        logic        ov;
        logic        ud;
        logic [2:0]  r;
        start = errors;
        cycle = 0;
        sent  = 0;
        idle  = 0;
        while ((sent < stream_len || word_q.size() > 0) && idle <= wait_limit) begin
            @(negedge clk);
            cycle++;
            if (out_valid === 1'b1) begin
                if (word_q.size() == 0) begin
                    $display("result strobe with no product in flight");
                    errors++;
                end else begin
                    check_word("fp_z", word_q.pop_front(), fp_z);
                    ov = flag_q[0][1];
                    ud = flag_q[0][0];
                    void'(flag_q.pop_front());
                    check_flag("ovrf", ov, ovrf);
                    check_flag("udrf", ud, udrf);
                    if (cycle - issue_q[0] != latency) begin
                        $display("result came %0d cycles after its operands", cycle - issue_q[0]);
                        errors++;
                    end
                    void'(issue_q.pop_front());
                end
            end
            if (sent < stream_len) begin
                in_valid = 1'b1;
                fp_x     = random_operand();
                fp_y     = random_operand();
                r        = 3'(draw() >> 29);
                r_mode   = rmode_t'(r);
                fp_mul_ref(fp_x.raw, fp_y.raw, r_mode, z, ov, ud);
                word_q.push_back(z);
                flag_q.push_back({ov, ud});
                issue_q.push_back(cycle);
                sent++;
            end else begin
                in_valid = 1'b0;
                idle++;
            end
        end
        in_valid = 1'b0;
        if (word_q.size() > 0) begin
            $display("%0d streamed results never came out", word_q.size());
            errors++;
        end
        report_test("streaming", start);
    endtask

    initial begin
        in_valid     = 1'b0;
        fp_x         = '0;
        fp_y         = '0;
        r_mode       = rne;
        errors       = 0;
        tests_passed = 0;
        tests_failed = 0;
        lcg_state    = lcg_seed;
        wait_reset();
        test_exact();
        test_rounding_modes();
        test_specials();
        test_overflow_underflow();
        test_round_carry();
        test_stream();
        $display("tests passed %0d, tests failed %0d, mismatches %0d",
                 tests_passed, tests_failed, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// File: sim/tb_clock_gen.sv
module tb_clock_gen (
    output logic clk,
    output logic rst_n
);

    localparam int half_period  = 4;
    localparam int reset_cycles = 8;

    initial begin
        clk = 1'b0;
        forever #half_period clk = ~clk;
    end

    // release on a falling edge, away from the sampling edge
    initial begin
        rst_n = 1'b0;
        repeat (reset_cycles) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    end

endmodule

// File: sources.f
hdl/fp_mul_pkg.sv
hdl/fp_mul_unpack.sv
hdl/fp_mul_booth.sv
hdl/fp_mul_norm.sv
hdl/fp_mul_round.sv
hdl/fp_mul_top.sv
sim/fp_mul_model.sv
sim/tb_clock_gen.sv
sim/fp_mul_tb.sv
